// ==== project.f ====
rtl/tetris_ctrl_pkg.sv
rtl/tetris_geom_pkg.sv
rtl/tetris_input_sync.sv
rtl/tetris_game_fsm.sv
rtl/tetris_piece_raster.sv
rtl/tetris_board.sv
rtl/tetris_display.sv
rtl/tetris_top.sv
test/tetris_top_sva.sv
test/tetris_tb.sv

// ==== rtl/tetris_board.sv ====
module tetris_board (
    input  logic                         clk,
    input  logic                         reset,
    input  tetris_ctrl_pkg::game_state_t state_i,
    input  tetris_geom_pkg::board_t      overlay_i,
    output tetris_geom_pkg::board_t      board_o,
    output tetris_geom_pkg::board_t      clearing_o,
    output logic                         top_full_o,
    output logic                         scan_done_o,
    output logic [7:0]                   score_o
);

    // locked cells
    tetris_geom_pkg::board_t board_q;
    // working copy while lines are cleared
    tetris_geom_pkg::board_t clear_q;
    // clear_q with the scanned row removed
    tetris_geom_pkg::board_t shifted;
    logic [4:0]              scan_row_q;
    logic                    scan_done_q;
    logic [7:0]              score_q;
    logic                    row_full;
    logic                    scan_active;

    assign row_full    = &clear_q[scan_row_q];
    assign scan_active = (state_i == tetris_ctrl_pkg::EVAL) && !scan_done_q;

    // rows above the scan row drop by one, empty row enters at the top
    always_comb begin
        shifted = clear_q;
        for (int k = 0; k < tetris_geom_pkg::board_rows_c; k++) begin
            if (k == 0) begin
                shifted[k] = '0;
            end else if (k <= int'(scan_row_q)) begin
                shifted[k] = clear_q[k-1];
            end
        end
    end

    // control and locked board
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            board_q     <= '0;
            scan_row_q  <= 5'(tetris_geom_pkg::board_rows_c - 1);
            scan_done_q <= 1'b0;
            score_q     <= 8'd0;
        end else begin
            case (state_i)
                // lock the piece
                tetris_ctrl_pkg::STUCK: board_q <= board_q | overlay_i;
                // start the scan at the bottom row
                tetris_ctrl_pkg::LANDED: begin
                    scan_row_q  <= 5'(tetris_geom_pkg::board_rows_c - 1);
                    scan_done_q <= 1'b0;
                end
                tetris_ctrl_pkg::EVAL: begin
                    if (scan_done_q) begin
                        board_q <= clear_q;
                    end else if (row_full) begin
                        // same row again for cascading clears
                        if (score_q != 8'hff) begin
                            score_q <= score_q + 8'd1;
                        end
                    end else if (scan_row_q == 5'd0) begin
                        scan_done_q <= 1'b1;
                    end else begin
                        scan_row_q <= scan_row_q - 5'd1;
                    end
                end
                default: ;
            endcase
        end
    end

    // working copy, loaded before every scan
    always_ff @(posedge clk) begin
        if (state_i == tetris_ctrl_pkg::LANDED) begin
            clear_q <= board_q;
        end else if (scan_active && row_full) begin
            clear_q <= shifted;
        end
    end

    assign board_o     = board_q;
    assign clearing_o  = clear_q;
    assign top_full_o  = |board_q[0];
    assign scan_done_o = scan_done_q;
    assign score_o     = score_q;

endmodule

// ==== rtl/tetris_ctrl_pkg.sv ====
package tetris_ctrl_pkg;

    // top level game flow
    typedef enum logic [2:0] {
        INIT,
        SPAWN,
        FALLING,
        STUCK,
        LANDED,
        EVAL,
        GAMEOVER
    } game_state_t;

    // spawn order, the counter walks this list and wraps
    typedef enum logic [2:0] {
        PIECE_I,
        PIECE_O,
        PIECE_J,
        PIECE_L,
        PIECE_S,
        PIECE_Z,
        PIECE_T
    } piece_kind_t;

    // which image goes to the output register
    typedef enum logic [1:0] {
        VIEW_BOARD,
        VIEW_OVERLAY,
        VIEW_CLEARING
    } view_t;

    // single cycle move pulses from the input side
    typedef struct packed {
        logic fall;
        logic left;
        logic right;
    } move_req_t;

endpackage

// ==== rtl/tetris_display.sv ====
module tetris_display (
    input  logic                         clk,
    input  logic                         reset,
    input  tetris_ctrl_pkg::game_state_t state_i,
    input  tetris_geom_pkg::board_t      board_i,
    input  tetris_geom_pkg::board_t      overlay_i,
    input  tetris_geom_pkg::board_t      clearing_i,
    output tetris_geom_pkg::board_t      display_o,
    output logic                         gameover_o
);

    tetris_ctrl_pkg::view_t  view;
    tetris_geom_pkg::board_t image;

    // piece is visible while it exists, clear board while scanning
    always_comb begin
        case (state_i)
            tetris_ctrl_pkg::SPAWN,
            tetris_ctrl_pkg::FALLING,
            tetris_ctrl_pkg::STUCK: view = tetris_ctrl_pkg::VIEW_OVERLAY;
            tetris_ctrl_pkg::EVAL:  view = tetris_ctrl_pkg::VIEW_CLEARING;
            default:                view = tetris_ctrl_pkg::VIEW_BOARD;
        endcase
    end

    always_comb begin
        case (view)
            tetris_ctrl_pkg::VIEW_OVERLAY:  image = overlay_i | board_i;
            tetris_ctrl_pkg::VIEW_CLEARING: image = clearing_i;
            default:                        image = board_i;
        endcase
    end

    // one clock of image latency
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            display_o  <= '0;
            gameover_o <= 1'b0;
        end else begin
            display_o  <= image;
            gameover_o <= (state_i == tetris_ctrl_pkg::GAMEOVER);
        end
    end

endmodule

// ==== rtl/tetris_game_fsm.sv ====
module tetris_game_fsm (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start_i,
    input  tetris_ctrl_pkg::move_req_t   move_i,
    input  logic                         collide_down_i,
    input  logic                         collide_left_i,
    input  logic                         collide_right_i,
    input  logic                         top_full_i,
    input  logic                         scan_done_i,
    output tetris_ctrl_pkg::game_state_t state_o,
    output tetris_geom_pkg::pattern_t    pattern_o,
    output tetris_geom_pkg::piece_pos_t  pos_o
);

    tetris_ctrl_pkg::game_state_t state_q;
    tetris_ctrl_pkg::game_state_t state_d;
    // kind handed out at the next spawn
    tetris_ctrl_pkg::piece_kind_t kind_q;
    tetris_geom_pkg::pattern_t    pattern_q;
    tetris_geom_pkg::piece_pos_t  pos_q;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            tetris_ctrl_pkg::INIT: begin
                if (start_i) begin
                    state_d = tetris_ctrl_pkg::SPAWN;
                end
            end
            tetris_ctrl_pkg::SPAWN: state_d = tetris_ctrl_pkg::FALLING;
            tetris_ctrl_pkg::FALLING: begin
                // landing wins over any move this cycle
                if (collide_down_i) begin
                    state_d = tetris_ctrl_pkg::STUCK;
                end
            end
            // board locks the piece here
            tetris_ctrl_pkg::STUCK: state_d = tetris_ctrl_pkg::LANDED;
            tetris_ctrl_pkg::LANDED: begin
                // locked cell in row 0 ends the game
                if (top_full_i) begin
                    state_d = tetris_ctrl_pkg::GAMEOVER;
                end else begin
                    state_d = tetris_ctrl_pkg::EVAL;
                end
            end
            tetris_ctrl_pkg::EVAL: begin
                if (scan_done_i) begin
                    state_d = tetris_ctrl_pkg::SPAWN;
                end
            end
            // sticky until reset
            tetris_ctrl_pkg::GAMEOVER: state_d = tetris_ctrl_pkg::GAMEOVER;
            default: state_d = tetris_ctrl_pkg::INIT;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q   <= tetris_ctrl_pkg::INIT;
            kind_q    <= tetris_ctrl_pkg::PIECE_I;
            pattern_q <= '0;
            pos_q     <= '{row: tetris_geom_pkg::spawn_row_c, col: tetris_geom_pkg::spawn_col_c};
        end else begin
            state_q <= state_d;
            if (state_q == tetris_ctrl_pkg::SPAWN) begin
                // new piece at the spawn point
                pattern_q <= tetris_geom_pkg::piece_shape(kind_q);
                pos_q.row <= tetris_geom_pkg::spawn_row_c;
                pos_q.col <= tetris_geom_pkg::spawn_col_c;
                // cyclic order, T wraps back to I
                if (kind_q == tetris_ctrl_pkg::PIECE_T) begin
                    kind_q <= tetris_ctrl_pkg::PIECE_I;
                end else begin
                    kind_q <= tetris_ctrl_pkg::piece_kind_t'(kind_q + 3'd1);
                end
            end else if (state_q == tetris_ctrl_pkg::FALLING && !collide_down_i) begin
                if (move_i.fall) begin
                    pos_q.row <= pos_q.row + 5'd1;
                end
                // left has priority, a blocked left also drops a right press
                if (move_i.left) begin
                    if (!collide_left_i) begin
                        pos_q.col <= pos_q.col - 4'd1;
                    end
                end else if (move_i.right && !collide_right_i) begin
                    pos_q.col <= pos_q.col + 4'd1;
                end
            end
        end
    end

    assign state_o   = state_q;
    assign pattern_o = pattern_q;
    assign pos_o     = pos_q;

endmodule

// ==== rtl/tetris_geom_pkg.sv ====
package tetris_geom_pkg;

    // playfield size, row 0 at the top
    localparam int board_rows_c = 20;
    localparam int board_cols_c = 10;
    // side of the square box that holds a piece
    localparam int piece_box_c = 4;
    // where a new piece appears
    localparam logic [3:0] spawn_col_c = 4'd3;
    localparam logic [4:0] spawn_row_c = 5'd0;

    // one row, indexed by column
    typedef logic [board_cols_c-1:0] row_t;
    // whole field, indexed [row][col]
    typedef row_t [board_rows_c-1:0] board_t;
    // piece box, indexed [row][col]
    typedef logic [piece_box_c-1:0][piece_box_c-1:0] pattern_t;

    // top-left corner of the piece box on the field
    typedef struct packed {
        logic [4:0] row;
        logic [3:0] col;
    } piece_pos_t;

    // spawn orientation of each kind, packed to the top-left of the box
    // row literals read right to left, bit 0 is column 0
    function automatic pattern_t piece_shape(tetris_ctrl_pkg::piece_kind_t kind);
        pattern_t p;
        p = '0;
        case (kind)
            tetris_ctrl_pkg::PIECE_I: p[0] = 4'b1111;
            tetris_ctrl_pkg::PIECE_O: begin
                p[0] = 4'b0011;
                p[1] = 4'b0011;
            end
            tetris_ctrl_pkg::PIECE_J: begin
                p[0] = 4'b0010;
                p[1] = 4'b0010;
                p[2] = 4'b0011;
            end
            tetris_ctrl_pkg::PIECE_L: begin
                p[0] = 4'b0001;
                p[1] = 4'b0001;
                p[2] = 4'b0011;
            end
            tetris_ctrl_pkg::PIECE_S: begin
                p[0] = 4'b0110;
                p[1] = 4'b0011;
            end
            tetris_ctrl_pkg::PIECE_Z: begin
                p[0] = 4'b0011;
                p[1] = 4'b0110;
            end
            tetris_ctrl_pkg::PIECE_T: begin
                p[0] = 4'b0111;
                p[1] = 4'b0010;
            end
            default: p = '0;
        endcase
        return p;
    endfunction

endpackage

// ==== rtl/tetris_input_sync.sv ====
module tetris_input_sync (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       fall_clk_i,
    input  logic                       left_i,
    input  logic                       right_i,
    input  logic                       start_i,
    output tetris_ctrl_pkg::move_req_t move_o,
    output logic                       start_o
);

    // bit 0 fall clock, bit 1 left, bit 2 right, bit 3 start
    logic [3:0] raw;
    logic [3:0] sync_q1;
    logic [3:0] sync_q2;
    // previous synchronized level, edge detect only
    logic [2:0] prev_q;

    assign raw = {start_i, right_i, left_i, fall_clk_i};

    // two flops per input, then one more for the edge detectors
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
            prev_q  <= '0;
        end else begin
            sync_q1 <= raw;
            sync_q2 <= sync_q1;
            prev_q  <= sync_q2[2:0];
        end
    end

    // fall on the high to low edge of the slow clock
    assign move_o.fall  = prev_q[0] & ~sync_q2[0];
    // buttons act on press
    assign move_o.left  = sync_q2[1] & ~prev_q[1];
    assign move_o.right = sync_q2[2] & ~prev_q[2];

    // start is a level, no edge needed
    assign start_o = sync_q2[3];

endmodule

// ==== rtl/tetris_piece_raster.sv ====
module tetris_piece_raster (
    input  tetris_geom_pkg::pattern_t   pattern_i,
    input  tetris_geom_pkg::piece_pos_t pos_i,
    input  tetris_geom_pkg::board_t     board_i,
    output tetris_geom_pkg::board_t     overlay_o,
    output logic                        collide_down_o,
    output logic                        collide_left_o,
    output logic                        collide_right_o
);

    always_comb begin
        // absolute field coordinates of the box cell
        int ar;
        int ac;
        overlay_o       = '0;
        collide_down_o  = 1'b0;
        collide_left_o  = 1'b0;
        collide_right_o = 1'b0;
        for (int r = 0; r < tetris_geom_pkg::piece_box_c; r++) begin
            for (int c = 0; c < tetris_geom_pkg::piece_box_c; c++) begin
                ar = int'(pos_i.row) + r;
                ac = int'(pos_i.col) + c;
                if (pattern_i[r][c]) begin
                    // only cells inside the field are drawn
                    if (ar < tetris_geom_pkg::board_rows_c &&
                        ac < tetris_geom_pkg::board_cols_c) begin
                        overlay_o[ar][ac] = 1'b1;
                    end
                    // floor, or a locked cell right below
                    if (ar + 1 >= tetris_geom_pkg::board_rows_c) begin
                        collide_down_o = 1'b1;
                    end else if (ac < tetris_geom_pkg::board_cols_c && board_i[ar+1][ac]) begin
                        collide_down_o = 1'b1;
                    end
                    // left wall, or locked neighbour
                    if (ac == 0) begin
                        collide_left_o = 1'b1;
                    end else if (ar < tetris_geom_pkg::board_rows_c &&
                                 ac <= tetris_geom_pkg::board_cols_c && board_i[ar][ac-1]) begin
                        collide_left_o = 1'b1;
                    end
                    // right wall, or locked neighbour
                    if (ac + 1 >= tetris_geom_pkg::board_cols_c) begin
                        collide_right_o = 1'b1;
                    end else if (ar < tetris_geom_pkg::board_rows_c && board_i[ar][ac+1]) begin
                        collide_right_o = 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== rtl/tetris_top.sv ====
module tetris_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start_i,
    input  logic                    fall_clk_i,
    input  logic                    left_i,
    input  logic                    right_i,
    output tetris_geom_pkg::board_t display_o,
    output logic                    gameover_o,
    output logic [7:0]              score_o
);

    tetris_ctrl_pkg::move_req_t   move;
    logic                         start_sync;
    tetris_ctrl_pkg::game_state_t state;
    tetris_geom_pkg::pattern_t    pattern;
    tetris_geom_pkg::piece_pos_t  pos;
    tetris_geom_pkg::board_t      overlay;
    tetris_geom_pkg::board_t      board;
    tetris_geom_pkg::board_t      clearing;
    logic                         collide_down;
    logic                         collide_left;
    logic                         collide_right;
    logic                         top_full;
    logic                         scan_done;

    // raw inputs to move pulses
    tetris_input_sync input_sync_i (
        .clk        (clk),
        .reset      (reset),
        .fall_clk_i (fall_clk_i),
        .left_i     (left_i),
        .right_i    (right_i),
        .start_i    (start_i),
        .move_o     (move),
        .start_o    (start_sync)
    );

    tetris_game_fsm game_fsm_i (
        .clk             (clk),
        .reset           (reset),
        .start_i         (start_sync),
        .move_i          (move),
        .collide_down_i  (collide_down),
        .collide_left_i  (collide_left),
        .collide_right_i (collide_right),
        .top_full_i      (top_full),
        .scan_done_i     (scan_done),
        .state_o         (state),
        .pattern_o       (pattern),
        .pos_o           (pos)
    );

    // active piece on the field, checked against locked cells
    tetris_piece_raster piece_raster_i (
        .pattern_i       (pattern),
        .pos_i           (pos),
        .board_i         (board),
        .overlay_o       (overlay),
        .collide_down_o  (collide_down),
        .collide_left_o  (collide_left),
        .collide_right_o (collide_right)
    );

    tetris_board board_i (
        .clk         (clk),
        .reset       (reset),
        .state_i     (state),
        .overlay_i   (overlay),
        .board_o     (board),
        .clearing_o  (clearing),
        .top_full_o  (top_full),
        .scan_done_o (scan_done),
        .score_o     (score_o)
    );

    tetris_display display_i (
        .clk        (clk),
        .reset      (reset),
        .state_i    (state),
        .board_i    (board),
        .overlay_i  (overlay),
        .clearing_i (clearing),
        .display_o  (display_o),
        .gameover_o (gameover_o)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tetris_tb \
    -f project.f -o tetris_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tetris_sim +verilator+error+limit+1000 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "TEST PASSED" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $LOG"
exit 1

// ==== test/tetris_tb.sv ====
module tetris_tb;

    // spawn shape cells as (row, col) in kind order I O J L S Z T
    localparam int cell_r_c [7][4] = '{
        '{0, 0, 0, 0}, '{0, 0, 1, 1}, '{0, 1, 2, 2}, '{0, 1, 2, 2},
        '{0, 0, 1, 1}, '{0, 0, 1, 1}, '{0, 0, 0, 1}
    };
    localparam int cell_c_c [7][4] = '{
        '{0, 1, 2, 3}, '{0, 1, 0, 1}, '{1, 1, 1, 0}, '{0, 0, 0, 1},
        '{1, 2, 0, 1}, '{0, 1, 1, 2}, '{0, 1, 2, 1}
    };
    localparam int kind_i_c = 0;
    localparam int kind_o_c = 1;
    localparam int kind_j_c = 2;
    localparam int kind_l_c = 3;
    localparam int kind_s_c = 4;
    // cycle budgets of tests 1 to 5, plus slack for the watchdog
    localparam int budget_c = 150 + 400 + 900 + 2600 + 3300;
    localparam int margin_c = 500;

    logic                    clk;
    logic                    reset;
    logic                    start_i;
    logic                    fall_clk_i;
    logic                    left_i;
    logic                    right_i;
    tetris_geom_pkg::board_t display_o;
    logic                    gameover_o;
    logic [7:0]              score_o;

    // locked cells as the rules predict them
    tetris_geom_pkg::board_t locked;
    logic [31:0]             lfsr_q;
    int                      errors;
    int                      checks;

    tetris_top tetris_top_i (
        .clk        (clk),
        .reset      (reset),
        .start_i    (start_i),
        .fall_clk_i (fall_clk_i),
        .left_i     (left_i),
        .right_i    (right_i),
        .display_o  (display_o),
        .gameover_o (gameover_o),
        .score_o    (score_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // fibonacci with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // piece drawn on an empty field
    function automatic tetris_geom_pkg::board_t piece_image(input int kind, input int row,
                                                            input int col);
        tetris_geom_pkg::board_t img;
        img = '0;
        for (int i = 0; i < 4; i++) begin
            img[row + cell_r_c[kind][i]][col + cell_c_c[kind][i]] = 1'b1;
        end
        return img;
    endfunction

    function automatic int piece_width(input int kind);
        int w;
        w = 0;
        for (int i = 0; i < 4; i++) begin
            if (cell_c_c[kind][i] + 1 > w) begin
                w = cell_c_c[kind][i] + 1;
            end
        end
        return w;
    endfunction

    // all drives and samples land 2 units after the rising edge
    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // 0 to 7 idle cycles from three lfsr bits
    task automatic idle_random();
        logic [2:0] n;
        n = '0;
        for (int i = 0; i < 3; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            n = {n[1:0], lfsr_q[0]};
        end
        step(int'(n));
    endtask

    // one period of the slow clock whose falling edge moves the piece
    task automatic fall_once();
        fall_clk_i = 1'b1;
        step(4);
        fall_clk_i = 1'b0;
        step(4);
    endtask

    // held for 4 cycles, then released so the next press is a new edge
    task automatic press_button(input bit go_left);
        if (go_left) begin
            left_i = 1'b1;
        end else begin
            right_i = 1'b1;
        end
        step(4);
        left_i  = 1'b0;
        right_i = 1'b0;
        step(4);
    endtask

    // poll up to budget cycles, then the check proper
    task automatic expect_image(input tetris_geom_pkg::board_t exp, input int budget,
                                input string what);
        int n;
        n = 0;
        while (display_o !== exp && n < budget) begin
            step(1);
            n++;
        end
        checks++;
        assert (display_o === exp) else begin
            $display("FAIL display_o (%s) got %h expected %h", what, display_o, exp);
            errors++;
        end
    endtask

    task automatic expect_score(input logic [7:0] exp);
        checks++;
        assert (score_o === exp) else begin
            $display("FAIL score_o got %h expected %h", score_o, exp);
            errors++;
        end
    endtask

    task automatic expect_gameover(input logic exp);
        checks++;
        assert (gameover_o === exp) else begin
            $display("FAIL gameover_o got %h expected %h", gameover_o, exp);
            errors++;
        end
    endtask

    // presses in one direction while col tracks the expected column
    task automatic shift_piece(input int kind, input int row, inout int col,
                               input bit go_left, input int presses);
        for (int i = 0; i < presses; i++) begin
            press_button(go_left);
            if (go_left && col > 0) begin
                col--;
            end else if (!go_left && col < tetris_geom_pkg::board_cols_c - piece_width(kind)) begin
                col++;
            end
            expect_image(locked | piece_image(kind, row, col), 8, "shift");
            idle_random();
        end
    endtask

    // falls down to the landing row, then the piece joins the locked cells
    task automatic drop_piece(input int kind, input int from_row, input int col,
                              input int land_row);
        for (int r = from_row + 1; r <= land_row; r++) begin
            fall_once();
            expect_image(locked | piece_image(kind, r, col), 8, "fall");
            idle_random();
        end
        locked = locked | piece_image(kind, land_row, col);
    endtask

    // scan time depends on the clears, so poll with a wide budget
    task automatic wait_spawn(input int kind);
        expect_image(locked | piece_image(kind, 0, 3), 60, "next spawn");
    endtask

    task automatic report_test(input int num, input string name, input int mark);
        $display("test %0d %s: %s", num, name, (errors == mark) ? "ok" : "failed");
    endtask

    initial begin
        int                      mark;
        int                      row;
        int                      col;
        int                      falls;
        int                      sva_fails;
        tetris_geom_pkg::board_t frozen;
        reset      = 1'b1;
        start_i    = 1'b0;
        fall_clk_i = 1'b0;
        left_i     = 1'b0;
        right_i    = 1'b0;
        lfsr_q     = 32'hd187;
        locked     = '0;
        errors     = 0;
        checks     = 0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        // idle after reset where moves without start do nothing
        mark = errors;
        step(2);
        expect_image('0, 0, "after reset");
        expect_score(8'd0);
        expect_gameover(1'b0);
        fall_once();
        press_button(1'b1);
        press_button(1'b0);
        idle_random();
        expect_image('0, 0, "without start");
        expect_score(8'd0);
        expect_gameover(1'b0);
        report_test(1, "reset idle", mark);

        // first piece is I at the spawn point
        mark    = errors;
        start_i = 1'b1;
        row     = 0;
        col     = 3;
        expect_image(piece_image(kind_i_c, row, col), 12, "spawn");
        repeat (2) begin
            fall_once();
            row++;
            expect_image(piece_image(kind_i_c, row, col), 8, "fall");
            idle_random();
        end
        report_test(2, "spawn and fall", mark);

        // one press past each wall
        mark = errors;
        shift_piece(kind_i_c, row, col, 1'b0, 4);
        shift_piece(kind_i_c, row, col, 1'b1, 7);
        report_test(3, "shift limits", mark);

        // fill the bottom row with I O J L
        mark = errors;
        drop_piece(kind_i_c, row, col, 19);
        wait_spawn(kind_o_c);
        col = 3;
        shift_piece(kind_o_c, 0, col, 1'b0, 1);
        drop_piece(kind_o_c, 0, col, 18);
        wait_spawn(kind_j_c);
        col = 3;
        shift_piece(kind_j_c, 0, col, 1'b0, 3);
        drop_piece(kind_j_c, 0, col, 17);
        wait_spawn(kind_l_c);
        col = 3;
        shift_piece(kind_l_c, 0, col, 1'b0, 5);
        drop_piece(kind_l_c, 0, col, 17);
        // row 19 clears and the rows above drop by one
        locked        = '0;
        locked[19][4] = 1'b1;
        locked[19][5] = 1'b1;
        locked[19][7] = 1'b1;
        locked[19][8] = 1'b1;
        locked[18][7] = 1'b1;
        locked[18][8] = 1'b1;
        wait_spawn(kind_s_c);
        expect_score(8'd1);
        report_test(4, "line clear", mark);

        // stack pieces at the spawn column until the top row fills
        mark  = errors;
        falls = 0;
        while (gameover_o !== 1'b1 && falls < 300) begin
            fall_once();
            falls++;
        end
        checks++;
        assert (gameover_o === 1'b1) else begin
            $display("game over was not reached after %0d fall cycles", falls);
            errors++;
        end
        step(2);
        frozen = display_o;
        fall_once();
        press_button(1'b1);
        press_button(1'b0);
        step(8);
        expect_image(frozen, 0, "after game over");
        expect_gameover(1'b1);
        report_test(5, "game over", mark);

        sva_fails = tetris_top_i.top_sva_i.fail_count;
        $display("summary: 5 tests, %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, sva_fails);
        if (errors == 0 && sva_fails == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // run limit from the test budgets
    initial begin
        #((budget_c + margin_c) * 20);
        $display("watchdog expired, run did not finish within %0d cycles", budget_c + margin_c);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== test/tetris_top_sva.sv ====
module tetris_top_sva (
    input logic                         clk,
    input logic                         reset,
    input tetris_ctrl_pkg::game_state_t state_i,
    input tetris_geom_pkg::board_t      display_i,
    input logic                         gameover_i,
    input logic [7:0]                   score_i
);

    // read by the testbench summary
    int unsigned fail_count = 0;

    // one cleared line per clock at most, saturation holds the value
    score_step_a: assert property (
        @(posedge clk) disable iff (reset)
        (score_i == $past(score_i)) || (score_i == $past(score_i) + 8'd1)
    ) else begin
        $error("score changed by more than one in a cycle");
        fail_count++;
    end

    // only reset leaves game over
    gameover_sticky_a: assert property (
        @(posedge clk) disable iff (reset)
        gameover_i |=> gameover_i
    ) else begin
        $error("gameover_o dropped without reset");
        fail_count++;
    end

    // nothing is drawn before start
    idle_dark_a: assert property (
        @(posedge clk) disable iff (reset)
        (state_i == tetris_ctrl_pkg::INIT) |-> (display_i == '0)
    ) else begin
        $error("display_o not blank while idle");
        fail_count++;
    end

endmodule

bind tetris_top tetris_top_sva top_sva_i (
    .clk        (clk),
    .reset      (reset),
    .state_i    (state),
    .display_i  (display_o),
    .gameover_i (gameover_o),
    .score_i    (score_o)
);
